/* design/dcache_pkg.sv */
`default_nettype none

package dcache_pkg;

  typedef logic [31:0] word_t;

  localparam int IDX_W     = 3;
  localparam int N_SETS    = 2 ** IDX_W;
  localparam int BLK_WORDS = 2;
  localparam int BLKOFF_W  = 1;
  localparam int BYTOFF_W  = 2;
  localparam int TAG_W     = 32 - IDX_W - BLKOFF_W - BYTOFF_W;

  // one word seen either flat or split into its cache fields.
  typedef union packed {
    word_t raw;
    struct packed {
      logic [TAG_W-1:0]    tag;
      logic [IDX_W-1:0]    idx;
      logic [BLKOFF_W-1:0] blkoff;
      logic [BYTOFF_W-1:0] bytoff;
    } f;
  } dcache_addr_t;

  // read-out of one frame, 92 bits.
  typedef struct packed {
    logic                        valid;
    logic                        dirty;
    logic [TAG_W-1:0]            tag;
    word_t [BLK_WORDS-1:0]       data;
  } frame_t;

endpackage

`default_nettype wire

/* design/dcache_frame_array.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_frame_array (
  input  logic                     CLK,
  input  logic                     nRST,
  input  dcache_pkg::dcache_addr_t addr,
  input  logic                     set_valid,
  input  logic                     clear_dirty,
  input  logic                     write_tag,
  input  logic                     store_data,
  input  dcache_pkg::word_t        store_word,
  output dcache_pkg::frame_t       frame,
  output logic                     hit
);

  import dcache_pkg::*;

  logic [N_SETS-1:0] valid;
  logic [N_SETS-1:0] dirty;
  logic [TAG_W-1:0]  tags [N_SETS];
  word_t             data_mem [N_SETS][BLK_WORDS];

  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
    begin
      valid <= '0;
      dirty <= '0;
    end
    else
    begin
      if (set_valid)
        valid[addr.f.idx] <= 1'b1;
      if (clear_dirty)
        dirty[addr.f.idx] <= 1'b0; // fill brings a clean block.
      else if (store_data)
        dirty[addr.f.idx] <= 1'b1;
    end
  end

  always_ff @(posedge CLK)
  begin
    if (write_tag)
      tags[addr.f.idx] <= addr.f.tag;
    if (store_data)
      data_mem[addr.f.idx][addr.f.blkoff] <= store_word;
  end

  always_comb
  begin
    frame.valid = valid[addr.f.idx];
    frame.dirty = dirty[addr.f.idx];
    frame.tag   = tags[addr.f.idx];
    for (int w = 0; w < BLK_WORDS; w++)
    begin
      frame.data[w] = data_mem[addr.f.idx][w];
    end
  end

  assign hit = frame.valid && (frame.tag == addr.f.tag);

endmodule

`default_nettype wire

/* design/dcache_control_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_control_unit #(
  parameter dcache_pkg::word_t HIT_COUNT_ADDR = 32'h0000_3100
) (
  input  logic                     CLK,
  input  logic                     nRST,
  input  logic                     enable,
  input  logic                     halt,
  input  logic                     dwait,
  input  logic                     frame_sel,
  input  logic                     hit,
  input  dcache_pkg::word_t        dmemaddr,
  input  dcache_pkg::frame_t       frame0,
  input  dcache_pkg::frame_t       frame1,
  input  dcache_pkg::word_t        hit_count,
  output dcache_pkg::dcache_addr_t cache_addr,
  output logic                     load_data,
  output logic                     set_valid,
  output logic                     clear_dirty,
  output logic                     write_tag,
  output logic                     disable_hit_counter,
  output logic                     dREN,
  output logic                     dWEN,
  output dcache_pkg::word_t        daddr,
  output dcache_pkg::word_t        dstore,
  output logic                     flushed
);

  import dcache_pkg::*;

  localparam logic [3:0] S_IDLE      = 4'd0;
  localparam logic [3:0] S_WB0       = 4'd1;
  localparam logic [3:0] S_WB1       = 4'd2;
  localparam logic [3:0] S_FETCH0    = 4'd3;
  localparam logic [3:0] S_FETCH1    = 4'd4;
  localparam logic [3:0] S_FLUSH     = 4'd5;
  localparam logic [3:0] S_FLUSH_WB0 = 4'd6;
  localparam logic [3:0] S_FLUSH_WB1 = 4'd7;
  localparam logic [3:0] S_COUNT     = 4'd8;
  localparam logic [3:0] S_FLUSHED   = 4'd9;

  logic [3:0]       state;
  logic [3:0]       next_state;
  logic [IDX_W-1:0] flush_idx;
  logic             flush_way;
  logic             flush_adv;
  logic             flush_last;
  logic             flushing;
  logic             fill_d;
  dcache_addr_t     req_addr;
  dcache_addr_t     wb_addr;
  frame_t           victim;

  assign req_addr.raw = dmemaddr;
  assign flushing     = (state == S_FLUSH) || (state == S_FLUSH_WB0) || (state == S_FLUSH_WB1);
  assign flush_last   = (&flush_idx) && flush_way;

  // the flush walk reads its own way, a miss evicts the LRU way.
  assign victim = (flushing ? flush_way : frame_sel) ? frame1 : frame0;

  always_comb
  begin
    cache_addr = req_addr;
    if (state == S_FETCH0 || state == S_FETCH1)
    begin
      cache_addr.f.blkoff = (state == S_FETCH1); // words land in order.
      cache_addr.f.bytoff = '0;
    end
    else if (flushing)
      cache_addr.f.idx = flush_idx;
  end

  always_comb
  begin
    wb_addr          = cache_addr;
    wb_addr.f.tag    = victim.tag;
    wb_addr.f.blkoff = (state == S_WB1) || (state == S_FLUSH_WB1);
    wb_addr.f.bytoff = '0;
  end

  always_comb
  begin
    next_state  = state;
    dREN        = 1'b0;
    dWEN        = 1'b0;
    daddr       = wb_addr.raw;
    dstore      = victim.data[wb_addr.f.blkoff];
    load_data   = 1'b0;
    set_valid   = 1'b0;
    clear_dirty = 1'b0;
    write_tag   = 1'b0;
    flush_adv   = 1'b0;
    flushed     = 1'b0;
    case (state)
      S_IDLE:
        if (halt)
          next_state = S_FLUSH;
        else if (enable && !hit)
          next_state = (victim.valid && victim.dirty) ? S_WB0 : S_FETCH0;
      S_WB0, S_WB1:
      begin
        dWEN = 1'b1;
        if (!dwait)
          next_state = (state == S_WB0) ? S_WB1 : S_FETCH0;
      end
      S_FETCH0, S_FETCH1:
      begin
        dREN        = 1'b1;
        daddr       = cache_addr.raw;
        load_data   = 1'b1;
        clear_dirty = 1'b1;
        set_valid   = (state == S_FETCH1); // tag and valid go with the last word.
        write_tag   = (state == S_FETCH1);
        if (!dwait)
          next_state = (state == S_FETCH0) ? S_FETCH1 : S_IDLE;
      end
      S_FLUSH:
        if (victim.valid && victim.dirty)
          next_state = S_FLUSH_WB0;
        else
        begin
          flush_adv  = 1'b1;
          next_state = flush_last ? S_COUNT : S_FLUSH;
        end
      S_FLUSH_WB0, S_FLUSH_WB1:
      begin
        dWEN = 1'b1;
        if (!dwait)
        begin
          if (state == S_FLUSH_WB0)
            next_state = S_FLUSH_WB1;
          else
          begin
            flush_adv  = 1'b1;
            next_state = flush_last ? S_COUNT : S_FLUSH;
          end
        end
      end
      S_COUNT:
      begin
        dWEN   = 1'b1;
        daddr  = HIT_COUNT_ADDR;
        dstore = hit_count;
        if (!dwait)
          next_state = S_FLUSHED;
      end
      S_FLUSHED:
        flushed = 1'b1;
      default:
        next_state = S_IDLE;
    endcase
  end

  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
    begin
      state     <= S_IDLE;
      flush_idx <= '0;
      flush_way <= 1'b0;
      fill_d    <= 1'b0;
    end
    else
    begin
      state  <= next_state;
      fill_d <= load_data;
      if (flush_adv)
        {flush_idx, flush_way} <= {flush_idx, flush_way} + 1'b1; // way 0 then way 1 per set.
    end
  end

  // the hit that closes a fill was not a first-cycle hit.
  assign disable_hit_counter = (state != S_IDLE) || fill_d;

endmodule

`default_nettype wire

/* design/dcache.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache #(
  parameter dcache_pkg::word_t HIT_COUNT_ADDR = 32'h0000_3100
) (
  input  logic              CLK,
  input  logic              nRST,
  input  logic              dmemREN,
  input  logic              dmemWEN,
  input  logic              halt,
  input  logic              dwait,
  input  dcache_pkg::word_t dmemaddr,
  input  dcache_pkg::word_t dmemstore,
  input  dcache_pkg::word_t dload,
  output logic              dhit,
  output logic              flushed,
  output logic              dREN,
  output logic              dWEN,
  output dcache_pkg::word_t dmemload,
  output dcache_pkg::word_t daddr,
  output dcache_pkg::word_t dstore
);

  import dcache_pkg::*;

  logic              enable;
  logic              frame_sel;
  logic [1:0]        way_hit;
  logic [N_SETS-1:0] lru;
  word_t             hit_count;
  dcache_addr_t      cache_addr;
  frame_t            frame0;
  frame_t            frame1;
  logic              load_data;
  logic              fill_valid;
  logic              fill_clear;
  logic              fill_tag;
  logic              disable_hit_counter;
  logic [1:0]        store_data;
  logic [1:0]        set_valid;
  logic [1:0]        clear_dirty;
  logic [1:0]        write_tag;
  word_t             store_word [2];

  assign enable    = dmemREN | dmemWEN;
  assign frame_sel = lru[cache_addr.f.idx];
  assign dhit      = enable & (|way_hit);

  dcache_frame_array way0 (
    .CLK         (CLK),
    .nRST        (nRST),
    .addr        (cache_addr),
    .set_valid   (set_valid[0]),
    .clear_dirty (clear_dirty[0]),
    .write_tag   (write_tag[0]),
    .store_data  (store_data[0]),
    .store_word  (store_word[0]),
    .frame       (frame0),
    .hit         (way_hit[0])
  );

  dcache_frame_array way1 (
    .CLK         (CLK),
    .nRST        (nRST),
    .addr        (cache_addr),
    .set_valid   (set_valid[1]),
    .clear_dirty (clear_dirty[1]),
    .write_tag   (write_tag[1]),
    .store_data  (store_data[1]),
    .store_word  (store_word[1]),
    .frame       (frame1),
    .hit         (way_hit[1])
  );

  dcache_control_unit #(
    .HIT_COUNT_ADDR (HIT_COUNT_ADDR)
  ) u_control (
    .CLK                 (CLK),
    .nRST                (nRST),
    .enable              (enable),
    .halt                (halt),
    .dwait               (dwait),
    .frame_sel           (frame_sel),
    .hit                 (|way_hit),
    .dmemaddr            (dmemaddr),
    .frame0              (frame0),
    .frame1              (frame1),
    .hit_count           (hit_count),
    .cache_addr          (cache_addr),
    .load_data           (load_data),
    .set_valid           (fill_valid),
    .clear_dirty         (fill_clear),
    .write_tag           (fill_tag),
    .disable_hit_counter (disable_hit_counter),
    .dREN                (dREN),
    .dWEN                (dWEN),
    .daddr               (daddr),
    .dstore              (dstore),
    .flushed             (flushed)
  );

  // store hits go to the hitting way, fills only to the LRU way.
  always_comb
  begin
    for (int w = 0; w < 2; w++)
    begin
      store_data[w]  = 1'b0;
      set_valid[w]   = 1'b0;
      clear_dirty[w] = 1'b0;
      write_tag[w]   = 1'b0;
      store_word[w]  = '0;
      if (way_hit[w] && dmemWEN)
      begin
        store_data[w] = 1'b1;
        store_word[w] = dmemstore;
      end
      else if (!dwait && (frame_sel == w[0]))
      begin
        store_data[w]  = load_data;
        set_valid[w]   = fill_valid;
        clear_dirty[w] = fill_clear;
        write_tag[w]   = fill_tag;
        store_word[w]  = dload;
      end
    end
  end

  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
    begin
      lru       <= '0;
      hit_count <= '0;
    end
    else
    begin
      if (enable && way_hit[0])
        lru[cache_addr.f.idx] <= 1'b1; // way 1 is now the victim.
      else if (enable && way_hit[1])
        lru[cache_addr.f.idx] <= 1'b0;
      if (dhit && !disable_hit_counter)
        hit_count <= hit_count + 32'd1;
    end
  end

  assign dmemload = way_hit[1] ? frame1.data[cache_addr.f.blkoff] : frame0.data[cache_addr.f.blkoff];

endmodule

`default_nettype wire

/* dv/tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
  output logic CLK,
  output logic nRST
);

  initial
  begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK; // 8 ns period.
  end

  initial
  begin
    nRST = 1'b0;
    repeat (3) @(posedge CLK);
    @(negedge CLK);
    nRST = 1'b1;
  end

endmodule

`default_nettype wire

/* dv/dcache_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_tb;

  import dcache_pkg::*;

  localparam word_t HIT_ADDR       = 32'h0000_3100;
  localparam int    N_RANDOM       = 400;
  localparam int    N_DIRECTED     = 7;
  localparam int    TIMEOUT_CYCLES = (N_RANDOM + N_DIRECTED) * 12 + 2000;

  logic  CLK;
  logic  nRST;
  logic  dmemREN;
  logic  dmemWEN;
  logic  halt;
  logic  dwait;
  word_t dmemaddr;
  word_t dmemstore;
  word_t dload;
  logic  dhit;
  logic  flushed;
  logic  dREN;
  logic  dWEN;
  word_t dmemload;
  word_t daddr;
  word_t dstore;

  integer seed          = 32'h6a42_95d2;
  int     cycle_count   = 0;
  int     value_errors  = 0;
  int     other_errors  = 0;
  int     strobe_cycles = 0;
  int     wait_left;
  logic   busy;
  word_t  mem [word_t];
  word_t  wr_log [$];

  word_t             model_mem [word_t];
  logic              m_valid [N_SETS][2];
  logic              m_dirty [N_SETS][2];
  logic [TAG_W-1:0]  m_tag [N_SETS][2];
  word_t             m_data [N_SETS][2][2];
  logic [N_SETS-1:0] m_lru;
  word_t             m_hits;

  tb_clock clock_gen (
    .CLK  (CLK),
    .nRST (nRST)
  );

  dcache #(
    .HIT_COUNT_ADDR (HIT_ADDR)
  ) dut (
    .CLK       (CLK),
    .nRST      (nRST),
    .dmemREN   (dmemREN),
    .dmemWEN   (dmemWEN),
    .halt      (halt),
    .dwait     (dwait),
    .dmemaddr  (dmemaddr),
    .dmemstore (dmemstore),
    .dload     (dload),
    .dhit      (dhit),
    .flushed   (flushed),
    .dREN      (dREN),
    .dWEN      (dWEN),
    .dmemload  (dmemload),
    .daddr     (daddr),
    .dstore    (dstore)
  );

  function automatic word_t mem_pattern(input word_t a);
    return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]};
  endfunction

  function automatic word_t mem_read(input word_t a);
    if (mem.exists(a))
      return mem[a];
    return mem_pattern(a);
  endfunction

  function automatic word_t model_read(input word_t a);
    if (model_mem.exists(a))
      return model_mem[a];
    return mem_pattern(a);
  endfunction

  // memory with 0 to 3 wait cycles per word, a word completes where dwait is low.
  initial
  begin
    dwait = 1'b1;
    dload = '0;
    busy  = 1'b0;
    wait_left = 0;
    forever
    begin
      @(negedge CLK);
      dwait = 1'b1;
      if (!nRST || !(dREN || dWEN))
        busy = 1'b0;
      else
      begin
        strobe_cycles++;
        if (!busy)
        begin
          busy      = 1'b1;
          wait_left = $random(seed) & 3;
        end
        if (wait_left == 0)
        begin
          dwait = 1'b0;
          busy  = 1'b0;
          if (dWEN)
          begin
            mem[daddr] = dstore;
            wr_log.push_back(daddr);
          end
          else
            dload = mem_read(daddr);
        end
        else
          wait_left--;
      end
    end
  end

  always @(posedge CLK)
  begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES)
    begin
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TEST FAILED");
      $finish;
    end
  end

  task automatic check_load(input word_t addr, input word_t expected, input word_t actual);
    if (actual !== expected)
    begin
      $display("FAIL t=%0t dmemload[%h]: expected %h, actual %h", $time, addr, expected, actual);
      value_errors++;
    end
  endtask

  task automatic check_mem(input word_t addr, input word_t expected, input word_t actual);
    if (actual !== expected)
    begin
      $display("FAIL t=%0t mem[%h]: expected %h, actual %h", $time, addr, expected, actual);
      value_errors++;
    end
  endtask

  task automatic check_count(input word_t expected, input word_t actual);
    if (actual !== expected)
    begin
      $display("FAIL t=%0t hit_count: expected %0d, actual %0d", $time, expected, actual);
      value_errors++;
    end
  endtask

  // hold the request from a falling edge until dhit, sampled mid-cycle.
  task automatic issue_request(input logic wr, input word_t addr, input word_t wdata,
                               output word_t rdata, output logic first_hit);
    @(negedge CLK);
    dmemREN   = !wr;
    dmemWEN   = wr;
    dmemaddr  = addr;
    dmemstore = wdata;
    #1;
    first_hit = dhit;
    while (!dhit)
    begin
      @(negedge CLK);
      #1;
    end
    rdata = dmemload;
  endtask

  task automatic predict_access(input logic wr, input dcache_addr_t a, input word_t wdata,
                                output word_t rdata, output logic hit);
    logic             way;
    logic [IDX_W-1:0] idx;
    dcache_addr_t     v;
    idx = a.f.idx;
    hit = 1'b0;
    way = 1'b0;
    for (int w = 0; w < 2; w++)
    begin
      if (m_valid[idx][w] && m_tag[idx][w] == a.f.tag)
      begin
        hit = 1'b1;
        way = w[0];
      end
    end
    if (hit)
      m_hits = m_hits + 32'd1;
    else
    begin
      way = m_lru[idx]; // replace the way not hit most recently.
      v   = a;
      v.f.bytoff = '0;
      for (int b = 0; b < 2; b++)
      begin
        v.f.blkoff = b[0];
        if (m_valid[idx][way] && m_dirty[idx][way])
        begin
          v.f.tag = m_tag[idx][way];
          model_mem[v.raw] = m_data[idx][way][b];
        end
        v.f.tag = a.f.tag;
        m_data[idx][way][b] = model_read(v.raw);
      end
      m_valid[idx][way] = 1'b1;
      m_dirty[idx][way] = 1'b0;
      m_tag[idx][way]   = a.f.tag;
    end
    m_lru[idx] = (way == 1'b0);
    if (wr)
    begin
      m_data[idx][way][a.f.blkoff] = wdata;
      m_dirty[idx][way] = 1'b1;
    end
    rdata = m_data[idx][way][a.f.blkoff];
  endtask

  task automatic flush_model();
    dcache_addr_t v;
    for (int s = 0; s < N_SETS; s++)
    begin
      for (int w = 0; w < 2; w++)
      begin
        if (m_valid[s][w] && m_dirty[s][w])
        begin
          for (int b = 0; b < 2; b++)
          begin
            v.raw      = '0;
            v.f.tag    = m_tag[s][w];
            v.f.idx    = s[IDX_W-1:0];
            v.f.blkoff = b[0];
            model_mem[v.raw] = m_data[s][w][b];
          end
        end
      end
    end
    model_mem[HIT_ADDR] = m_hits;
  endtask

  task automatic request_and_check(input logic wr, input word_t addr, input word_t wdata,
                                   output word_t rdata, output logic hit);
    dcache_addr_t a;
    word_t        expected;
    logic         model_hit;
    a.raw = addr;
    predict_access(wr, a, wdata, expected, model_hit);
    issue_request(wr, addr, wdata, rdata, hit);
    if (!wr)
      check_load(addr, expected, rdata);
    if (hit !== model_hit)
    begin
      $display("first-cycle hit at address %h differs from the reference model", addr);
      other_errors++;
    end
  endtask

  initial
  begin
    word_t  rdata;
    word_t  addr;
    logic   hit;
    integer r;
    int     mark;
    dmemREN   = 1'b0;
    dmemWEN   = 1'b0;
    halt      = 1'b0;
    dmemaddr  = '0;
    dmemstore = '0;
    for (int s = 0; s < N_SETS; s++)
    begin
      for (int w = 0; w < 2; w++)
      begin
        m_valid[s][w] = 1'b0;
        m_dirty[s][w] = 1'b0;
      end
    end
    m_lru  = '0;
    m_hits = '0;
    wait (nRST === 1'b1);

    request_and_check(1'b0, 32'h0000_2010, '0, rdata, hit);
    check_load(32'h0000_2010, mem_pattern(32'h0000_2010), rdata);
    mark = strobe_cycles;
    request_and_check(1'b0, 32'h0000_2014, '0, rdata, hit);
    if (!hit || strobe_cycles != mark)
    begin
      $display("second word of a fetched block did not hit without memory traffic");
      other_errors++;
    end

    mark = wr_log.size();
    request_and_check(1'b1, 32'h0000_2014, 32'h5eed_0b0e, rdata, hit);
    request_and_check(1'b0, 32'h0000_2014, '0, rdata, hit);
    check_load(32'h0000_2014, 32'h5eed_0b0e, rdata);
    if (wr_log.size() != mark)
    begin
      $display("memory was written by a store hit before any eviction or flush");
      other_errors++;
    end

    // three tags on set 5, the third evicts the dirty way 0.
    request_and_check(1'b1, 32'h0000_2028, 32'hc0de_7a11, rdata, hit);
    request_and_check(1'b0, 32'h0000_2068, '0, rdata, hit);
    mark = wr_log.size();
    request_and_check(1'b0, 32'h0000_20a8, '0, rdata, hit);
    if (wr_log.size() != mark + 2)
    begin
      $display("dirty victim eviction did not write exactly two words to memory");
      other_errors++;
    end
    else if (wr_log[mark] != 32'h0000_2028 || wr_log[mark + 1] != 32'h0000_202c)
    begin
      $display("dirty victim was written back at the wrong addresses");
      other_errors++;
    end
    check_mem(32'h0000_2028, 32'hc0de_7a11, mem_read(32'h0000_2028));
    check_mem(32'h0000_202c, mem_pattern(32'h0000_202c), mem_read(32'h0000_202c));

    for (int i = 0; i < N_RANDOM; i++)
    begin
      r    = $random(seed);
      addr = 32'h0000_1000 | (r & 32'h0000_00fc); // four tags on every set.
      request_and_check(r[8], addr, $random(seed), rdata, hit);
    end

    @(negedge CLK);
    dmemREN = 1'b0;
    dmemWEN = 1'b0;
    halt    = 1'b1;
    flush_model();
    #1;
    while (!flushed)
    begin
      @(negedge CLK);
      #1;
    end

    foreach (model_mem[a])
      check_mem(a, model_mem[a], mem_read(a));
    foreach (mem[a])
    begin
      if (!model_mem.exists(a))
      begin
        $display("memory at %h was written with no write in the reference model", a);
        other_errors++;
      end
    end
    check_count(m_hits, mem_read(HIT_ADDR));

    $display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0)
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* dcache.f */
design/dcache_pkg.sv
design/dcache_frame_array.sv
design/dcache_control_unit.sv
design/dcache.sv
dv/tb_clock.sv
dv/dcache_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -f dcache.f --top-module dcache_tb -o dcache_sim

out=$(./obj_dir/dcache_sim)
echo "$out"

if echo "$out" | grep -qx "TEST PASSED"; then
  exit 0
fi
exit 1
